// File: rtl/groovy_consts.svh
// constants shared by the blit engine RTL and the testbench
// memory map, group geometry, PLL table entries and reset modeline
`ifndef GROOVY_CONSTS_SVH
`define GROOVY_CONSTS_SVH

// memory map, in 64-bit word addresses
`define HEADER_ADDR      28'd0
`define MODELINE_ADDR    28'd1
`define PIXEL_BASE_ADDR  28'd16

// one group = 3 words = 8 pixels of 24 bits
`define WORDS_PER_GROUP  3
`define PIXELS_PER_GROUP 8

// PLL reconfiguration table
`define PLL_WRITE_COUNT  7
`define PLL_ADDR_MODE    6'd0
`define PLL_ADDR_M       6'd4
`define PLL_ADDR_N       6'd3
`define PLL_ADDR_C       6'd5
`define PLL_ADDR_K       6'd7
`define PLL_ADDR_BW      6'd8
`define PLL_ADDR_START   6'd2
`define PLL_N_VALUE      32'h00010000  // n counter bypassed
`define PLL_BW_VALUE     32'd6         // auto bandwidth

// reset modeline, 256x240 at 60 hz
`define DEF_H_ACTIVE     16'd256
`define DEF_H_FP         8'd10
`define DEF_H_SYNC       8'd24
`define DEF_H_BP         8'd41
`define DEF_V_ACTIVE     16'd240
`define DEF_V_FP         8'd2
`define DEF_V_SYNC       8'd3
`define DEF_V_BP         8'd16
`define DEF_PLL_M0       8'd4
`define DEF_PLL_M1       8'd4
`define DEF_PLL_C0       8'd3
`define DEF_PLL_C1       8'd2
`define DEF_PLL_K        32'd1182682725
`define DEFAULT_CE_DIV   8'd16

`endif

// File: rtl/groovy_pkg.sv
// types shared by the blit engine modules
// referenced by scoped name, never imported

package groovy_pkg;

	// memory side
	typedef logic [63:0]  mem_word_t;     // one memory data word
	typedef logic [27:0]  mem_addr_t;     // word address
	typedef logic [7:0]   burst_len_t;
	typedef logic [191:0] group_t;        // three words, word 0 lowest

	// pixel side
	typedef logic [23:0]  rgb_t;          // red in the top byte
	typedef logic [23:0]  frame_num_t;
	typedef logic [23:0]  pixel_count_t;

	// modeline and PLL
	typedef logic [15:0]  span_t;         // active width or height
	typedef logic [7:0]   porch_t;        // porch or sync width
	typedef logic [7:0]   pll_cnt_t;      // one counter byte
	typedef logic [31:0]  pll_frac_t;     // fractional k
	typedef logic [5:0]   cfg_addr_t;
	typedef logic [31:0]  cfg_data_t;

	typedef enum logic [2:0] {
		IDLE, DISPATCH, HDR_WAIT, GROUP_REQ, GROUP_WAIT, PIXEL_OUT, MODE_WAIT, MODE_APPLY
	} ctrl_state_t;

endpackage

// File: rtl/blit_ctrl.sv
// control FSM of the blit engine
// serves blit and switch commands, issues memory reads and sequences pixel groups
`include "groovy_consts.svh"

module blit_ctrl (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cmd_init,       // enable level for both strobes
	input  logic                   cmd_blit,
	input  logic                   cmd_switchres,
	input  logic                   vblank,
	input  logic                   mem_valid,
	input  groovy_pkg::mem_word_t  mem_data,
	input  logic                   pixels_done,    // eighth pixel of a group written
	output logic                   mem_rd,
	output groovy_pkg::mem_addr_t  mem_addr,
	output groovy_pkg::burst_len_t mem_burst,
	output logic                   pixel_start,
	output logic                   mode_load,
	output logic                   frame_done,
	output groovy_pkg::frame_num_t frame_num
);

	groovy_pkg::ctrl_state_t  state;
	logic                     pend_blit;
	logic                     pend_switch;
	groovy_pkg::burst_len_t   word_cnt;      // words received in this burst
	groovy_pkg::pixel_count_t groups_left;
	groovy_pkg::mem_addr_t    grp_addr;      // address of the next group
	groovy_pkg::frame_num_t   last_frame;    // newest frame already blitted
	groovy_pkg::frame_num_t   hdr_frame;     // frame being blitted
	groovy_pkg::frame_num_t   hdr_num;
	groovy_pkg::pixel_count_t hdr_count;
	logic                     last_word;

	// header word layout
	assign hdr_num   = mem_data[23:0];
	assign hdr_count = mem_data[47:24];
	assign last_word = mem_valid
		&& (word_cnt == groovy_pkg::burst_len_t'(`WORDS_PER_GROUP - 1));

	assign mode_load = (state == groovy_pkg::MODE_APPLY) && vblank;  // first vblank cycle
	assign frame_num = last_frame;

	////////////////////////////////////////////////////////////
	// pending commands

	always_ff @(posedge clk_sys) begin
		if (reset || !cmd_init) begin  // strobes lost while disabled
			pend_blit   <= 1'b0;
			pend_switch <= 1'b0;
		end else begin
			if (state == groovy_pkg::DISPATCH) begin
				if (pend_switch)
					pend_switch <= 1'b0;  // switch wins
				else if (pend_blit)
					pend_blit <= 1'b0;
			end
			if (cmd_switchres)
				pend_switch <= 1'b1;
			if (cmd_blit)
				pend_blit <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// main FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= groovy_pkg::IDLE;
			mem_rd      <= 1'b0;
			pixel_start <= 1'b0;
			frame_done  <= 1'b0;
			last_frame  <= '0;
		end else begin
			mem_rd      <= 1'b0;
			pixel_start <= 1'b0;
			frame_done  <= 1'b0;
			if (mem_valid)
				word_cnt <= word_cnt + 8'd1;
			case (state)
				groovy_pkg::IDLE: if (cmd_init) state <= groovy_pkg::DISPATCH;
				groovy_pkg::DISPATCH: begin
					word_cnt <= '0;
					if (!cmd_init) begin
						state <= groovy_pkg::IDLE;
					end else if (pend_switch) begin  // modeline record, one group
						mem_rd    <= 1'b1;
						mem_addr  <= `MODELINE_ADDR;
						mem_burst <= groovy_pkg::burst_len_t'(`WORDS_PER_GROUP);
						state     <= groovy_pkg::MODE_WAIT;
					end else if (pend_blit) begin
						mem_rd    <= 1'b1;
						mem_addr  <= `HEADER_ADDR;
						mem_burst <= 8'd1;  // header is a single word
						state     <= groovy_pkg::HDR_WAIT;
					end
				end
				groovy_pkg::HDR_WAIT: if (mem_valid) begin
					hdr_frame   <= hdr_num;
					groups_left <= groovy_pkg::pixel_count_t'(hdr_count / `PIXELS_PER_GROUP);
					grp_addr    <= `PIXEL_BASE_ADDR;
					// only a newer frame with at least one full group is drawn
					if (hdr_num > last_frame && hdr_count >= `PIXELS_PER_GROUP)
						state <= groovy_pkg::GROUP_REQ;
					else
						state <= groovy_pkg::DISPATCH;
				end
				groovy_pkg::GROUP_REQ: begin
					mem_rd    <= 1'b1;
					mem_addr  <= grp_addr;
					mem_burst <= groovy_pkg::burst_len_t'(`WORDS_PER_GROUP);
					word_cnt  <= '0;
					state     <= groovy_pkg::GROUP_WAIT;
				end
				groovy_pkg::GROUP_WAIT: if (last_word) begin
					pixel_start <= 1'b1;  // group complete in the assembler next cycle
					grp_addr    <= grp_addr + groovy_pkg::mem_addr_t'(`WORDS_PER_GROUP);
					groups_left <= groups_left - 24'd1;
					state       <= groovy_pkg::PIXEL_OUT;
				end
				groovy_pkg::PIXEL_OUT: if (pixels_done) begin
					if (groups_left == '0) begin
						frame_done <= 1'b1;
						last_frame <= hdr_frame;
						state      <= groovy_pkg::DISPATCH;
					end else begin
						state <= groovy_pkg::GROUP_REQ;
					end
				end
				groovy_pkg::MODE_WAIT: if (last_word) state <= groovy_pkg::MODE_APPLY;
				groovy_pkg::MODE_APPLY: if (vblank) state <= groovy_pkg::DISPATCH;
				default: state <= groovy_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: rtl/burst_assembler.sv
// gathers memory words into a three word group and writes its eight pixels to vram
// one pixel per cycle, starting the cycle after pixel_start

module burst_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mem_valid,
	input  groovy_pkg::mem_word_t mem_data,
	input  logic                  pixel_start,
	output groovy_pkg::group_t    group,        // last three words, oldest lowest
	output logic                  vram_we,
	output groovy_pkg::rgb_t      vram_pixel,
	output logic                  pixels_done
);

	groovy_pkg::group_t pix_sr;   // pixels still to send, next one lowest
	logic [2:0]         pix_cnt;  // pixel index within the group
	logic               busy;

	// new word enters at the top, oldest drops out at the bottom
	always_ff @(posedge clk_sys) begin
		if (mem_valid)
			group <= {mem_data, group[191:64]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy    <= 1'b0;
			pix_cnt <= '0;
		end else if (pixel_start) begin
			busy    <= 1'b1;
			pix_cnt <= '0;
		end else if (busy) begin
			pix_cnt <= pix_cnt + 3'd1;
			if (&pix_cnt)
				busy <= 1'b0;  // eighth pixel out
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pixel_start)
			pix_sr <= group;  // snapshot, free for the next burst
		else if (busy)
			pix_sr <= {24'd0, pix_sr[191:24]};
	end

	assign vram_we     = busy;
	assign vram_pixel  = pix_sr[23:0];
	assign pixels_done = busy && (&pix_cnt);

endmodule

// File: rtl/modeline_timing.sv
// active modeline and PLL counter registers, loaded from the switch record
// also divides clk_sys down to the pixel clock enable
`include "groovy_consts.svh"

module modeline_timing (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mode_load,    // apply the held record
	input  groovy_pkg::group_t    group,
	output groovy_pkg::span_t     h_active,
	output groovy_pkg::porch_t    h_fp,
	output groovy_pkg::porch_t    h_sync,
	output groovy_pkg::porch_t    h_bp,
	output groovy_pkg::span_t     v_active,
	output groovy_pkg::porch_t    v_fp,
	output groovy_pkg::porch_t    v_sync,
	output groovy_pkg::porch_t    v_bp,
	output groovy_pkg::pll_cnt_t  pll_m0,
	output groovy_pkg::pll_cnt_t  pll_m1,
	output groovy_pkg::pll_cnt_t  pll_c0,
	output groovy_pkg::pll_cnt_t  pll_c1,
	output groovy_pkg::pll_frac_t pll_k,
	output logic                  ce_pix,
	output logic                  mode_changed  // one cycle after mode_load
);

	groovy_pkg::pll_cnt_t ce_div;   // clk_sys cycles per pixel
	groovy_pkg::pll_cnt_t ce_cnt;
	groovy_pkg::pll_cnt_t ce_last;

	assign ce_last = (ce_div == '0) ? '0 : ce_div - 8'd1;  // div 0 runs as div 1
	assign ce_pix  = (ce_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{h_active, h_fp, h_sync, h_bp} <= {`DEF_H_ACTIVE, `DEF_H_FP, `DEF_H_SYNC, `DEF_H_BP};
			{v_active, v_fp, v_sync, v_bp} <= {`DEF_V_ACTIVE, `DEF_V_FP, `DEF_V_SYNC, `DEF_V_BP};
			{pll_m0, pll_m1, pll_c0, pll_c1} <= {`DEF_PLL_M0, `DEF_PLL_M1, `DEF_PLL_C0, `DEF_PLL_C1};
			pll_k        <= `DEF_PLL_K;
			ce_div       <= `DEFAULT_CE_DIV;
			ce_cnt       <= '0;
			mode_changed <= 1'b0;
		end else begin
			mode_changed <= mode_load;
			if (mode_load) begin
				// record offsets as laid out by the host
				h_active <= group[0 +: 16];
				h_fp     <= group[16 +: 8];
				h_sync   <= group[24 +: 8];
				h_bp     <= group[32 +: 8];
				v_active <= group[40 +: 16];
				v_fp     <= group[56 +: 8];
				v_sync   <= group[64 +: 8];
				v_bp     <= group[72 +: 8];
				pll_m0   <= group[80 +: 8];
				pll_m1   <= group[88 +: 8];
				pll_c0   <= group[96 +: 8];
				pll_c1   <= group[104 +: 8];
				pll_k    <= group[112 +: 32];
				ce_div   <= group[144 +: 8];
				ce_cnt   <= 8'd1;  // restart one past the enable, old and new never touch
			end else begin
				ce_cnt <= (ce_cnt >= ce_last) ? '0 : ce_cnt + 8'd1;
			end
		end
	end

endmodule

// File: rtl/pll_reconfig_seq.sv
// writes the seven entry PLL reconfiguration table after every modeline change
// one write per cycle with waitrequest low, restarted by a new mode_changed
`include "groovy_consts.svh"

module pll_reconfig_seq (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mode_changed,
	input  groovy_pkg::pll_cnt_t  pll_m0,
	input  groovy_pkg::pll_cnt_t  pll_m1,
	input  groovy_pkg::pll_cnt_t  pll_c0,
	input  groovy_pkg::pll_cnt_t  pll_c1,
	input  groovy_pkg::pll_frac_t pll_k,
	input  logic                  cfg_waitrequest,
	output logic                  cfg_write,
	output groovy_pkg::cfg_addr_t cfg_address,
	output groovy_pkg::cfg_data_t cfg_data
);

	logic       active;  // sequence in progress
	logic [2:0] idx;     // table entry on the port

	// no write on a restart cycle, entry 0 follows with the new values
	assign cfg_write = active && !cfg_waitrequest && !mode_changed;

	////////////////////////////////////////////////////////////
	// table, counters taken live from the modeline registers

	always_comb begin
		case (idx)
			3'd0: {cfg_address, cfg_data} = {`PLL_ADDR_MODE, 32'd0};  // waitrequest mode
			3'd1: {cfg_address, cfg_data} = {`PLL_ADDR_M, 16'd0, pll_m0, pll_m1};
			3'd2: {cfg_address, cfg_data} = {`PLL_ADDR_N, `PLL_N_VALUE};
			3'd3: {cfg_address, cfg_data} = {`PLL_ADDR_C, 16'd0, pll_c0, pll_c1};
			3'd4: {cfg_address, cfg_data} = {`PLL_ADDR_K, pll_k};
			3'd5: {cfg_address, cfg_data} = {`PLL_ADDR_BW, `PLL_BW_VALUE};
			default: {cfg_address, cfg_data} = {`PLL_ADDR_START, 32'd0};  // kick off
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active <= 1'b0;
			idx    <= '0;
		end else if (mode_changed) begin
			active <= 1'b1;
			idx    <= '0;
		end else if (cfg_write) begin  // advance on accept only
			if (idx == 3'(`PLL_WRITE_COUNT - 1)) begin
				active <= 1'b0;
				idx    <= '0;
			end else begin
				idx <= idx + 3'd1;
			end
		end
	end

endmodule

// File: rtl/groovy_blit_top.sv
// top level of the frame blit and mode switch engine
// control FSM, group assembler, modeline registers and PLL table writer

module groovy_blit_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cmd_init,
	input  logic                   cmd_blit,
	input  logic                   cmd_switchres,
	input  logic                   vblank,
	output logic                   mem_rd,          // memory read port
	output groovy_pkg::mem_addr_t  mem_addr,
	output groovy_pkg::burst_len_t mem_burst,
	input  logic                   mem_valid,
	input  groovy_pkg::mem_word_t  mem_data,
	output logic                   vram_we,         // video ram write port
	output groovy_pkg::rgb_t       vram_pixel,
	output logic                   frame_done,
	output groovy_pkg::frame_num_t frame_num,
	output groovy_pkg::span_t      h_active,        // active modeline
	output groovy_pkg::porch_t     h_fp,
	output groovy_pkg::porch_t     h_sync,
	output groovy_pkg::porch_t     h_bp,
	output groovy_pkg::span_t      v_active,
	output groovy_pkg::porch_t     v_fp,
	output groovy_pkg::porch_t     v_sync,
	output groovy_pkg::porch_t     v_bp,
	output logic                   ce_pix,
	input  logic                   cfg_waitrequest, // PLL reconfig port
	output logic                   cfg_write,
	output groovy_pkg::cfg_addr_t  cfg_address,
	output groovy_pkg::cfg_data_t  cfg_data
);

	// internal strobes
	logic pixel_start;
	logic pixels_done;
	logic mode_load;
	logic mode_changed;
	groovy_pkg::group_t    group;  // assembled words, also the modeline record
	groovy_pkg::pll_cnt_t  pll_m0;
	groovy_pkg::pll_cnt_t  pll_m1;
	groovy_pkg::pll_cnt_t  pll_c0;
	groovy_pkg::pll_cnt_t  pll_c1;
	groovy_pkg::pll_frac_t pll_k;

	// all ports connect by matching names
	blit_ctrl        i_blit_ctrl        (.*);
	burst_assembler  i_burst_assembler  (.*);
	modeline_timing  i_modeline_timing  (.*);
	pll_reconfig_seq i_pll_reconfig_seq (.*);

endmodule

// File: verification/groovy_sva.sv
// protocol assertions for the blit engine, bound into groovy_blit_top
// memory burst order, PLL port handshake, vram write runs and pixel enable spacing

module groovy_sva (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   mem_rd,
	input groovy_pkg::burst_len_t mem_burst,
	input logic                   mem_valid,
	input logic                   cfg_write,
	input logic                   cfg_waitrequest,
	input logic                   vram_we,
	input logic                   ce_pix,
	input groovy_pkg::pll_cnt_t   ce_div
);

	groovy_pkg::burst_len_t words_due;       // words still owed by memory
	int                     fail_count = 0;  // assertion failures so far

	always_ff @(posedge clk_sys) begin
		if (reset)
			words_due <= '0;
		else if (mem_rd)
			words_due <= mem_burst;
		else if (mem_valid && words_due != '0)
			words_due <= words_due - 8'd1;
	end

	rd_after_burst: assert property (@(posedge clk_sys) disable iff (reset)
		mem_rd |-> words_due == '0)
	else begin
		fail_count++;
		$error("mem_rd with a burst outstanding");
	end

	write_no_wait: assert property (@(posedge clk_sys) disable iff (reset)
		cfg_write |-> !cfg_waitrequest)
	else begin
		fail_count++;
		$error("cfg_write during waitrequest");
	end

	// one group is eight pixels back to back
	we_run_of_eight: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(vram_we) |-> vram_we [*8] ##1 !vram_we)
	else begin
		fail_count++;
		$error("vram_we run not eight");
	end

	ce_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_pix && ce_div > 8'd1) |=> !ce_pix)
	else begin
		fail_count++;
		$error("ce_pix high twice in a row");
	end

endmodule

bind groovy_blit_top groovy_sva i_sva (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.mem_rd          (mem_rd),
	.mem_burst       (mem_burst),
	.mem_valid       (mem_valid),
	.cfg_write       (cfg_write),
	.cfg_waitrequest (cfg_waitrequest),
	.vram_we         (vram_we),
	.ce_pix          (ce_pix),
	.ce_div          (i_modeline_timing.ce_div)  // held divider
);

// File: verification/groovy_tb.sv
// testbench for the frame blit and mode switch engine
// random blits and switches from a fixed seed against a memory model and reference queues
`include "groovy_consts.svh"

module groovy_tb;

	logic                   clk_sys;
	logic                   reset;
	logic                   cmd_init;
	logic                   cmd_blit;
	logic                   cmd_switchres;
	logic                   vblank;
	logic                   mem_rd;
	groovy_pkg::mem_addr_t  mem_addr;
	groovy_pkg::burst_len_t mem_burst;
	logic                   mem_valid;
	groovy_pkg::mem_word_t  mem_data;
	logic                   vram_we;
	groovy_pkg::rgb_t       vram_pixel;
	logic                   frame_done;
	groovy_pkg::frame_num_t frame_num;
	groovy_pkg::span_t      h_active;
	groovy_pkg::porch_t     h_fp;
	groovy_pkg::porch_t     h_sync;
	groovy_pkg::porch_t     h_bp;
	groovy_pkg::span_t      v_active;
	groovy_pkg::porch_t     v_fp;
	groovy_pkg::porch_t     v_sync;
	groovy_pkg::porch_t     v_bp;
	logic                   ce_pix;
	logic                   cfg_waitrequest;
	logic                   cfg_write;
	groovy_pkg::cfg_addr_t  cfg_address;
	groovy_pkg::cfg_data_t  cfg_data;

	integer                 seed = 32'h08770078;
	groovy_pkg::mem_word_t  mem [0:63];          // memory model
	groovy_pkg::rgb_t       exp_pix [$];         // pixels still to come, in order
	groovy_pkg::frame_num_t exp_frames [$];
	logic [37:0]            exp_cfg [$];         // {address, data} per PLL write
	groovy_pkg::mem_addr_t  read_addrs [$];      // every read, in issue order
	groovy_pkg::group_t     exp_rec = '0;        // record of the pending switch
	groovy_pkg::frame_num_t model_last = '0;     // newest frame drawn so far
	logic                   switch_pending = 1'b0;
	logic                   prev_vblank = 1'b0;
	logic [79:0]            last_mode = '0;
	int                     bursts_done = 0;
	int                     reads_seen = 0;
	int                     mode_updates = 0;

	groovy_blit_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic stop_on_error();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		stop_on_error();
	endtask

	// modeline outputs packed like bits 79:0 of the record
	function automatic logic [79:0] shown_mode();
		return {v_bp, v_sync, v_fp, v_active, h_bp, h_sync, h_fp, h_active};
	endfunction

	//////////////////////////////////////////////////////////////
	// memory model and random inputs

	task automatic serve_burst(input groovy_pkg::mem_addr_t addr,
			input groovy_pkg::burst_len_t len);
		int i;
		int gap;
		groovy_pkg::burst_len_t exp_len;
		exp_len = (addr == `HEADER_ADDR) ? 8'd1 : 8'(`WORDS_PER_GROUP);  // header or group
		assert (len == exp_len) else begin
			$display("[ERROR] %0t mem_burst expected %0d got %0d", $time, exp_len, len);
			stop_on_error();
		end
		read_addrs.push_back(addr);
		for (i = 0; i < int'(len); i++) begin
			gap = $unsigned($random(seed)) % 4;  // latency 1 to 4 on the first word
			@(posedge clk_sys);
			#10;
			mem_valid = 1'b0;
			repeat (gap) begin
				@(posedge clk_sys);
				#10;
			end
			mem_valid = 1'b1;
			mem_data  = mem[6'(addr) + 6'(i)];
		end
		@(posedge clk_sys);
		#10;
		mem_valid = 1'b0;
		bursts_done++;
	endtask

	initial begin
		mem_valid = 1'b0;
		mem_data  = '0;
		forever begin
			@(posedge clk_sys);
			#10;
			if (mem_rd && !reset) begin
				reads_seen++;
				serve_burst(mem_addr, mem_burst);
			end
		end
	end

	initial begin
		vblank          = 1'b0;
		cfg_waitrequest = 1'b0;
		forever begin
			@(posedge clk_sys);
			#10;
			vblank          = ($random(seed) & 3) == 0;  // about one cycle in four
			cfg_waitrequest = 1'($random(seed));
		end
	end

	//////////////////////////////////////////////////////////////
	// output checks sampled mid cycle

	always @(negedge clk_sys) begin
		assert (i_dut.i_sva.fail_count == 0) else begin
			$display("a protocol assertion failed before %0t", $time);
			stop_on_error();
		end
		if (!reset && vram_we) begin
			assert (exp_pix.size() > 0) else begin
				$display("pixel write with no pixel expected at %0t", $time);
				stop_on_error();
			end
			assert (vram_pixel == exp_pix[0]) else begin
				$display("[ERROR] %0t vram_pixel expected %h got %h", $time,
					exp_pix[0], vram_pixel);
				stop_on_error();
			end
			void'(exp_pix.pop_front());
		end
		if (!reset && frame_done) begin
			assert (exp_frames.size() > 0) else begin
				$display("frame_done with no frame expected at %0t", $time);
				stop_on_error();
			end
			assert (frame_num == exp_frames[0]) else begin
				$display("[ERROR] %0t frame_num expected %h got %h", $time,
					exp_frames[0], frame_num);
				stop_on_error();
			end
			void'(exp_frames.pop_front());
		end
		// a modeline change must follow a vblank cycle of a pending switch
		if (!reset && shown_mode() != last_mode) begin
			assert (switch_pending && prev_vblank) else begin
				$display("modeline outputs changed without a switch at vblank at %0t", $time);
				stop_on_error();
			end
			assert (shown_mode() == exp_rec[79:0]) else begin
				$display("[ERROR] %0t h_active..v_bp expected %h got %h", $time,
					exp_rec[79:0], shown_mode());
				stop_on_error();
			end
			exp_cfg.push_back({`PLL_ADDR_MODE, 32'd0});
			exp_cfg.push_back({`PLL_ADDR_M, 16'd0, exp_rec[80 +: 8], exp_rec[88 +: 8]});
			exp_cfg.push_back({`PLL_ADDR_N, `PLL_N_VALUE});
			exp_cfg.push_back({`PLL_ADDR_C, 16'd0, exp_rec[96 +: 8], exp_rec[104 +: 8]});
			exp_cfg.push_back({`PLL_ADDR_K, exp_rec[112 +: 32]});
			exp_cfg.push_back({`PLL_ADDR_BW, `PLL_BW_VALUE});
			exp_cfg.push_back({`PLL_ADDR_START, 32'd0});
			switch_pending = 1'b0;
			mode_updates++;
		end
		if (!reset && cfg_write) begin
			assert (!cfg_waitrequest && exp_cfg.size() > 0) else begin
				$display("PLL write during waitrequest or not expected at %0t", $time);
				stop_on_error();
			end
			assert ({cfg_address, cfg_data} == exp_cfg[0]) else begin
				$display("[ERROR] %0t cfg_address,cfg_data expected %h got %h", $time,
					exp_cfg[0], {cfg_address, cfg_data});
				stop_on_error();
			end
			void'(exp_cfg.pop_front());
		end
		last_mode   = shown_mode();
		prev_vblank = vblank;  // what the DUT sees at the next edge
	end

	//////////////////////////////////////////////////////////////
	// stimulus and reference model

	task automatic pulse_cmd(input logic blit, input logic sw);
		@(posedge clk_sys);
		#10;
		cmd_blit      = blit;
		cmd_switchres = sw;
		@(posedge clk_sys);
		#10;
		cmd_blit      = 1'b0;
		cmd_switchres = 1'b0;
	endtask

	task automatic check_ce_period(input int period);
		int t;
		int n;
		t = 0;
		n = 0;
		@(negedge clk_sys);
		while (!ce_pix) begin
			@(negedge clk_sys);
			t++;
			if (t > 400)
				report_timeout("ce_pix");
		end
		do begin
			@(negedge clk_sys);
			n++;
			if (n > 400)
				report_timeout("the next ce_pix");
		end while (!ce_pix);
		assert (n == period) else begin
			$display("[ERROR] %0t ce_pix period expected %0d got %0d", $time, period, n);
			stop_on_error();
		end
	endtask

	// writes a header and fresh pixels and queues what a blit must produce
	task automatic setup_blit(input logic newer);
		groovy_pkg::frame_num_t   frame;
		groovy_pkg::pixel_count_t count;
		groovy_pkg::group_t       grp;
		int g;
		int p;
		count = 24'($unsigned($random(seed)) % 40);  // up to four groups and some below eight
		if (newer)
			frame = model_last + 24'(1 + $unsigned($random(seed)) % 5);
		else
			frame = (model_last == '0) ? '0 : model_last - 24'(1'($random(seed)));  // equal or older
		mem[0] = {16'($random(seed)), count, frame};
		for (g = 16; g < 32; g++)
			mem[6'(g)] = {$random(seed), $random(seed)};
		if (frame > model_last && count >= 24'd8) begin
			for (g = 0; g < int'(count / 8); g++) begin
				grp = {mem[6'(18 + 3 * g)], mem[6'(17 + 3 * g)], mem[6'(16 + 3 * g)]};
				for (p = 0; p < 8; p++)
					exp_pix.push_back(grp[24 * p +: 24]);  // pixel 0 lowest
			end
			exp_frames.push_back(frame);
			model_last = frame;
		end
	endtask

	task automatic run_blit(input logic newer);
		int start;
		int t;
		start = bursts_done;
		t     = 0;
		setup_blit(newer);
		pulse_cmd(1'b1, 1'b0);
		while (exp_frames.size() > 0 || bursts_done == start) begin  // header read at least
			@(posedge clk_sys);
			t++;
			if (t > 3000)
				report_timeout("the blit");
		end
		assert (exp_pix.size() == 0) else begin
			$display("frame_done came before all pixels at %0t", $time);
			stop_on_error();
		end
	endtask

	task automatic run_switch(input logic with_blit);
		groovy_pkg::group_t rec;
		int start;
		int updates;
		int t;
		rec = {$random(seed), $random(seed), $random(seed),
			$random(seed), $random(seed), $random(seed)};
		rec[144 +: 8] = 8'($unsigned($random(seed)) % 7);  // small divider including 0
		mem[1] = rec[63:0];
		mem[2] = rec[127:64];
		mem[3] = rec[191:128];
		exp_rec        = rec;
		switch_pending = 1'b1;
		start          = bursts_done;
		updates        = mode_updates;
		t              = 0;
		if (with_blit)
			setup_blit(1'b1);
		pulse_cmd(with_blit, 1'b1);  // both pending together when with_blit
		while (mode_updates == updates || exp_cfg.size() > 0 || exp_frames.size() > 0
				|| bursts_done < start + (with_blit ? 2 : 1)) begin
			@(posedge clk_sys);
			t++;
			if (t > 4000)
				report_timeout("the mode switch");
		end
		assert (read_addrs[start] == `MODELINE_ADDR) else begin
			$display("[ERROR] %0t mem_addr expected %h got %h", $time,
				`MODELINE_ADDR, read_addrs[start]);
			stop_on_error();
		end
		check_ce_period((rec[144 +: 8] == 8'd0) ? 1 : int'(rec[144 +: 8]));
	endtask

	initial begin
		int i;
		reset         = 1'b1;
		cmd_init      = 1'b0;
		cmd_blit      = 1'b0;
		cmd_switchres = 1'b0;
		for (i = 0; i < 64; i++)
			mem[i] = {$random(seed), $random(seed)};
		repeat (2) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		check_ce_period(16);
		// commands while disabled are dropped and start nothing later
		mem[0] = {16'd0, 24'd16, 24'd5};
		pulse_cmd(1'b1, 1'b1);
		repeat (20) @(posedge clk_sys);
		#10;
		cmd_init = 1'b1;
		repeat (20) @(posedge clk_sys);
		assert (reads_seen == 0) else begin
			$display("memory read issued for a command given with cmd_init low");
			stop_on_error();
		end
		for (i = 0; i < 24; i++) begin
			case ($unsigned($random(seed)) % 4)
				0: run_blit(1'b1);
				1: run_blit(1'b0);   // stale frame
				2: run_switch(1'b0);
				default: run_switch(1'b1);
			endcase
		end
		repeat (10) @(posedge clk_sys);
		if (exp_pix.size() == 0 && exp_cfg.size() == 0 && exp_frames.size() == 0
				&& !switch_pending) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("expected outputs left over at the end of the run");
			stop_on_error();
		end
	end

endmodule

// File: files.f
+incdir+rtl
rtl/groovy_pkg.sv
rtl/blit_ctrl.sv
rtl/burst_assembler.sv
rtl/modeline_timing.sv
rtl/pll_reconfig_seq.sv
rtl/groovy_blit_top.sv
verification/groovy_sva.sv
verification/groovy_tb.sv
